//--- design/cpuPkg.sv
`default_nettype none

// ********************************************************
// Shared types and constants of the 8-bit core
// ********************************************************
package cpuPkg;

	// Data path widths
	typedef logic [7:0] byte_t;		// Data and instruction byte
	typedef logic [2:0] regIdx_t;	// DDD / SSS register field

	// Code and data address width, top level default
	localparam int DefaultAddrWidth = 14;

	// Register indexes as encoded in the opcode
	localparam regIdx_t RegA = 3'd0;	// Accumulator
	localparam regIdx_t RegH = 3'd5;	// Address high
	localparam regIdx_t RegL = 3'd6;	// Address low
	localparam regIdx_t RegM = 3'd7;	// Memory at {H,L}, no real register

	// Execute operations
	typedef enum logic [2:0] {
		OpPass,		// Result is the S operand
		OpAdd,
		OpSub,
		OpAnd,
		OpXor,
		OpOr
	} execOp_t;

endpackage

`default_nettype wire

//--- design/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
	parameter int AddrWidth = cpuPkg::DefaultAddrWidth
) (
	input  wire logic              CLK_I,
	input  wire logic              nRST_I,
	input  wire cpuPkg::byte_t     I_DAT_I,
	output logic [AddrWidth-1:0]   I_ADDR_O,
	output logic                   opValid,
	output cpuPkg::byte_t          opcode,
	output cpuPkg::byte_t          opImm
);

	typedef enum logic [1:0] {
		FetchOpcode,	// F3 holds an opcode
		SkipOne,		// F3 holds the last operand byte
		SkipTwo			// F3 holds the first of two operand bytes
	} fetchState_t;

	fetchState_t state;
	logic [AddrWidth-1:0] pc;

	// Byte pipeline
	cpuPkg::byte_t f1Byte;
	cpuPkg::byte_t f2Byte;
	cpuPkg::byte_t f3Byte;
	logic f1Valid;
	logic f2Valid;
	logic f3Valid;

	logic isTwoByte;
	logic isThreeByte;
	logic isZeroOp;

	assign I_ADDR_O = pc;

	// Length classes of the byte in F3
	assign isTwoByte   = (f3Byte[7:6] == 2'b00) && f3Byte[2] && !f3Byte[0];	// 00xxx1x0
	assign isThreeByte = (f3Byte[7:6] == 2'b01) && !f3Byte[0];				// 01xxxxx0
	assign isZeroOp    = (f3Byte[7:1] == 7'd0);	// 00000000 and 00000001

	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			pc <= '0;
		end else begin
			pc <= pc + 1'b1;	// One byte every cycle
		end
	end

	always_ff @(posedge CLK_I) begin
		f1Byte <= I_DAT_I;
		f2Byte <= f1Byte;
		f3Byte <= f2Byte;
	end

	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			f1Valid <= 1'b0;
			f2Valid <= 1'b0;
			f3Valid <= 1'b0;
		end else begin
			f1Valid <= 1'b1;
			f2Valid <= f1Valid;
			f3Valid <= f2Valid;
		end
	end

	// ********************************************************
	// Instruction length tracking, F3 -> D
	// ********************************************************
	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			state   <= FetchOpcode;
			opValid <= 1'b0;
		end else begin
			opValid <= 1'b0;
			case (state)
				FetchOpcode: begin
					if (f3Valid) begin
						opValid <= !isZeroOp;
						if (isThreeByte) begin
							state <= SkipTwo;
						end else if (isTwoByte) begin
							state <= SkipOne;
						end
					end
				end
				SkipTwo: begin
					state <= SkipOne;
				end
				default: begin
					state <= FetchOpcode;
				end
			endcase
		end
	end

	// Immediate is the byte right behind the opcode
	always_ff @(posedge CLK_I) begin
		if (state == FetchOpcode) begin
			opcode <= f3Byte;
			opImm  <= f2Byte;
		end
	end

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  wire logic             CLK_I,
	input  wire logic             nRST_I,
	input  wire cpuPkg::regIdx_t  srcIdx,
	input  wire logic             fwdEValid,
	input  wire cpuPkg::regIdx_t  fwdEDst,
	input  wire cpuPkg::byte_t    fwdEVal,
	input  wire logic             fwdMValid,
	input  wire cpuPkg::regIdx_t  fwdMDst,
	input  wire cpuPkg::byte_t    fwdMVal,
	input  wire logic             wbValid,
	input  wire cpuPkg::regIdx_t  wbDst,
	input  wire cpuPkg::byte_t    wbVal,
	output cpuPkg::byte_t         srcVal,
	output cpuPkg::byte_t         aVal,
	output cpuPkg::byte_t         hVal,
	output cpuPkg::byte_t         lVal
);

	cpuPkg::byte_t regs [8];
	logic wbHitsBank;

	// M is the memory operand, never a bank entry
	assign wbHitsBank = wbValid && (wbDst != cpuPkg::RegM);

	// ********************************************************
	// Register bank
	// ********************************************************
	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wbHitsBank) begin
			regs[wbDst] <= wbVal;
		end
	end

	// Youngest writer wins: E, then M, then W, then bank
	function automatic cpuPkg::byte_t readPort(cpuPkg::regIdx_t idx);
		cpuPkg::byte_t val;
		if (fwdEValid && (fwdEDst == idx)) begin
			val = fwdEVal;
		end else if (fwdMValid && (fwdMDst == idx)) begin
			val = fwdMVal;
		end else if (wbHitsBank && (wbDst == idx)) begin
			val = wbVal;		// Written at the end of this cycle
		end else begin
			val = regs[idx];
		end
		return val;
	endfunction

	// ********************************************************
	// Forwarded read ports
	// ********************************************************
	always_comb begin
		srcVal = readPort(srcIdx);
		aVal   = readPort(cpuPkg::RegA);
		hVal   = readPort(cpuPkg::RegH);	// Store address high
		lVal   = readPort(cpuPkg::RegL);	// Store address low
	end

endmodule

`default_nettype wire

//--- design/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input  wire logic             CLK_I,
	input  wire logic             nRST_I,
	input  wire logic             opValid,
	input  wire cpuPkg::byte_t    opcode,
	input  wire cpuPkg::byte_t    opImm,
	output cpuPkg::regIdx_t       srcIdx,
	input  wire cpuPkg::byte_t    srcVal,
	input  wire cpuPkg::byte_t    aVal,
	input  wire cpuPkg::byte_t    hVal,
	input  wire cpuPkg::byte_t    lVal,
	output logic                  exValid,
	output cpuPkg::execOp_t       exOp,
	output cpuPkg::regIdx_t       exDst,
	output logic                  exWrite,
	output logic                  exStore,
	output cpuPkg::byte_t         exA,
	output cpuPkg::byte_t         exS,
	output cpuPkg::byte_t         exH,
	output cpuPkg::byte_t         exL
);

	cpuPkg::regIdx_t dddField;
	cpuPkg::regIdx_t sssField;
	cpuPkg::execOp_t aluOp;
	logic aluKnown;

	// Instruction classes
	logic isInc, isDcr, isAluR, isAluI;
	logic isLrr, isLri, isLmr, isLmi;

	cpuPkg::execOp_t nextOp;
	cpuPkg::regIdx_t nextDst;
	cpuPkg::byte_t nextA;
	cpuPkg::byte_t nextS;
	logic doWrite;
	logic doStore;

	assign dddField = opcode[5:3];
	assign sssField = opcode[2:0];

	// OOO field, ADC SBB CMP are not kept
	always_comb begin
		aluKnown = 1'b1;
		case (dddField)
			3'b000:  aluOp = cpuPkg::OpAdd;
			3'b010:  aluOp = cpuPkg::OpSub;
			3'b100:  aluOp = cpuPkg::OpAnd;
			3'b101:  aluOp = cpuPkg::OpXor;
			3'b110:  aluOp = cpuPkg::OpOr;
			default: begin
				aluOp    = cpuPkg::OpPass;
				aluKnown = 1'b0;
			end
		endcase
	end

	assign isInc  = (opcode[7:6] == 2'b00) && (sssField == 3'b000) &&
	                (dddField != cpuPkg::RegA) && (dddField != cpuPkg::RegM);
	assign isDcr  = (opcode[7:6] == 2'b00) && (sssField == 3'b001) &&
	                (dddField != cpuPkg::RegA) && (dddField != cpuPkg::RegM);
	assign isAluR = (opcode[7:6] == 2'b10) && (sssField != cpuPkg::RegM) && aluKnown;
	assign isAluI = (opcode[7:6] == 2'b00) && (sssField == 3'b100) && aluKnown;
	assign isLrr  = (opcode[7:6] == 2'b11) && (dddField != cpuPkg::RegM) &&
	                (sssField != cpuPkg::RegM);
	assign isLmr  = (opcode[7:6] == 2'b11) && (dddField == cpuPkg::RegM) &&
	                (sssField != cpuPkg::RegM);
	assign isLri  = (opcode[7:6] == 2'b00) && (sssField == 3'b110) && (dddField != cpuPkg::RegM);
	assign isLmi  = (opcode[7:6] == 2'b00) && (sssField == 3'b110) && (dddField == cpuPkg::RegM);

	assign srcIdx = (isInc || isDcr) ? dddField : sssField;	// INC/DCR read their own DDD

	// ********************************************************
	// Operand selection
	// ********************************************************
	always_comb begin
		nextOp  = cpuPkg::OpPass;
		nextDst = dddField;
		nextA   = aVal;
		nextS   = srcVal;
		doWrite = 1'b0;
		doStore = 1'b0;
		if (isInc || isDcr) begin
			nextOp  = cpuPkg::OpAdd;
			nextA   = srcVal;
			nextS   = isInc ? 8'h01 : 8'hFF;	// DCR adds minus one
			doWrite = 1'b1;
		end else if (isAluR || isAluI) begin
			nextOp  = aluOp;
			nextDst = cpuPkg::RegA;
			nextS   = isAluI ? opImm : srcVal;
			doWrite = 1'b1;
		end else if (isLrr || isLri) begin
			nextS   = isLri ? opImm : srcVal;
			doWrite = 1'b1;
		end else if (isLmr || isLmi) begin
			nextS   = isLmi ? opImm : srcVal;
			doStore = 1'b1;
		end
	end

	// D -> E control
	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			exValid <= 1'b0;
			exWrite <= 1'b0;
			exStore <= 1'b0;
		end else begin
			exValid <= opValid;
			exWrite <= opValid & doWrite;
			exStore <= opValid & doStore;
		end
	end

	// D -> E payload
	always_ff @(posedge CLK_I) begin
		exOp  <= nextOp;
		exDst <= nextDst;
		exA   <= nextA;
		exS   <= nextS;
		exH   <= hVal;
		exL   <= lVal;
	end

endmodule

`default_nettype wire

//--- design/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input  wire logic             CLK_I,
	input  wire logic             nRST_I,
	input  wire logic             exValid,
	input  wire cpuPkg::execOp_t  exOp,
	input  wire cpuPkg::regIdx_t  exDst,
	input  wire logic             exWrite,
	input  wire logic             exStore,
	input  wire cpuPkg::byte_t    exA,
	input  wire cpuPkg::byte_t    exS,
	input  wire cpuPkg::byte_t    exH,
	input  wire cpuPkg::byte_t    exL,
	output logic                  fwdEValid,
	output cpuPkg::regIdx_t       fwdEDst,
	output cpuPkg::byte_t         fwdEVal,
	output logic                  memValid,
	output cpuPkg::regIdx_t       memDst,
	output logic                  memWrite,
	output logic                  memStore,
	output cpuPkg::byte_t         memResult,
	output cpuPkg::byte_t         memH,
	output cpuPkg::byte_t         memL
);

	cpuPkg::byte_t result;

	// ********************************************************
	// ALU, carry out is dropped
	// ********************************************************
	always_comb begin
		case (exOp)
			cpuPkg::OpAdd: result = exA + exS;
			cpuPkg::OpSub: result = exA - exS;
			cpuPkg::OpAnd: result = exA & exS;
			cpuPkg::OpXor: result = exA ^ exS;
			cpuPkg::OpOr:  result = exA | exS;
			default:       result = exS;		// Moves and stores
		endcase
	end

	// Bypass to decode in the same cycle
	assign fwdEValid = exValid & exWrite;
	assign fwdEDst   = exDst;
	assign fwdEVal   = result;

	// E -> M control
	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			memValid <= 1'b0;
			memWrite <= 1'b0;
			memStore <= 1'b0;
		end else begin
			memValid <= exValid;
			memWrite <= exValid & exWrite;
			memStore <= exValid & exStore;
		end
	end

	// E -> M payload
	always_ff @(posedge CLK_I) begin
		memDst    <= exDst;
		memResult <= result;
		memH      <= exH;
		memL      <= exL;
	end

endmodule

`default_nettype wire

//--- design/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage #(
	parameter int AddrWidth = cpuPkg::DefaultAddrWidth
) (
	input  wire logic             CLK_I,
	input  wire logic             nRST_I,
	input  wire logic             memValid,
	input  wire cpuPkg::regIdx_t  memDst,
	input  wire logic             memWrite,
	input  wire logic             memStore,
	input  wire cpuPkg::byte_t    memResult,
	input  wire cpuPkg::byte_t    memH,
	input  wire cpuPkg::byte_t    memL,
	output logic                  D_WE_O,
	output logic [AddrWidth-1:0]  D_ADDR_O,
	output cpuPkg::byte_t         D_DAT_O,
	output logic                  fwdMValid,
	output cpuPkg::regIdx_t       fwdMDst,
	output cpuPkg::byte_t         fwdMVal,
	output logic                  wbValid,
	output cpuPkg::regIdx_t       wbDst,
	output cpuPkg::byte_t         wbVal
);

	logic [15:0] hlAddr;

	// ********************************************************
	// Store port, one pulse per store while in M
	// ********************************************************
	assign hlAddr   = {memH, memL};
	assign D_WE_O   = memValid & memStore;
	assign D_ADDR_O = hlAddr[AddrWidth-1:0];		// Upper H bits fall off
	assign D_DAT_O  = memResult;

	assign fwdMValid = memValid & memWrite;
	assign fwdMDst   = memDst;
	assign fwdMVal   = memResult;

	// M -> W
	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= memValid & memWrite;
		end
	end

	always_ff @(posedge CLK_I) begin
		wbDst <= memDst;
		wbVal <= memResult;
	end

endmodule

`default_nettype wire

//--- design/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
	parameter int AddrWidth = cpuPkg::DefaultAddrWidth
) (
	input  wire logic             CLK_I,
	input  wire logic             nRST_I,
	input  wire cpuPkg::byte_t    I_DAT_I,
	output logic [AddrWidth-1:0]  I_ADDR_O,
	output logic                  D_WE_O,
	output logic [AddrWidth-1:0]  D_ADDR_O,
	output cpuPkg::byte_t         D_DAT_O
);

	// Fetch -> decode
	logic opValid;
	cpuPkg::byte_t opcode;
	cpuPkg::byte_t opImm;

	// Decode <-> register file
	cpuPkg::regIdx_t srcIdx;
	cpuPkg::byte_t srcVal, aVal, hVal, lVal;

	// Decode -> execute
	logic exValid, exWrite, exStore;
	cpuPkg::execOp_t exOp;
	cpuPkg::regIdx_t exDst;
	cpuPkg::byte_t exA, exS, exH, exL;

	// Execute -> memory
	logic memValid, memWrite, memStore;
	cpuPkg::regIdx_t memDst;
	cpuPkg::byte_t memResult, memH, memL;

	// Bypass and writeback
	logic fwdEValid, fwdMValid, wbValid;
	cpuPkg::regIdx_t fwdEDst, fwdMDst, wbDst;
	cpuPkg::byte_t fwdEVal, fwdMVal, wbVal;

	// ********************************************************
	// F1 F2 F3 -> D -> E -> M -> W
	// ********************************************************
	fetchStage #(.AddrWidth(AddrWidth)) i_fetch (
		.CLK_I(CLK_I), .nRST_I(nRST_I), .I_DAT_I(I_DAT_I), .I_ADDR_O(I_ADDR_O),
		.opValid(opValid), .opcode(opcode), .opImm(opImm)
	);

	regFile i_regs (
		.CLK_I(CLK_I), .nRST_I(nRST_I), .srcIdx(srcIdx),
		.fwdEValid(fwdEValid), .fwdEDst(fwdEDst), .fwdEVal(fwdEVal),
		.fwdMValid(fwdMValid), .fwdMDst(fwdMDst), .fwdMVal(fwdMVal),
		.wbValid(wbValid), .wbDst(wbDst), .wbVal(wbVal),
		.srcVal(srcVal), .aVal(aVal), .hVal(hVal), .lVal(lVal)
	);

	decodeStage i_decode (
		.CLK_I(CLK_I), .nRST_I(nRST_I), .opValid(opValid), .opcode(opcode), .opImm(opImm),
		.srcIdx(srcIdx), .srcVal(srcVal), .aVal(aVal), .hVal(hVal), .lVal(lVal),
		.exValid(exValid), .exOp(exOp), .exDst(exDst), .exWrite(exWrite), .exStore(exStore),
		.exA(exA), .exS(exS), .exH(exH), .exL(exL)
	);

	executeStage i_execute (
		.CLK_I(CLK_I), .nRST_I(nRST_I), .exValid(exValid), .exOp(exOp), .exDst(exDst),
		.exWrite(exWrite), .exStore(exStore), .exA(exA), .exS(exS), .exH(exH), .exL(exL),
		.fwdEValid(fwdEValid), .fwdEDst(fwdEDst), .fwdEVal(fwdEVal),
		.memValid(memValid), .memDst(memDst), .memWrite(memWrite), .memStore(memStore),
		.memResult(memResult), .memH(memH), .memL(memL)
	);

	memoryStage #(.AddrWidth(AddrWidth)) i_memory (
		.CLK_I(CLK_I), .nRST_I(nRST_I), .memValid(memValid), .memDst(memDst),
		.memWrite(memWrite), .memStore(memStore), .memResult(memResult),
		.memH(memH), .memL(memL),
		.D_WE_O(D_WE_O), .D_ADDR_O(D_ADDR_O), .D_DAT_O(D_DAT_O),
		.fwdMValid(fwdMValid), .fwdMDst(fwdMDst), .fwdMVal(fwdMVal),
		.wbValid(wbValid), .wbDst(wbDst), .wbVal(wbVal)
	);

endmodule

`default_nettype wire

//--- include/tbPrograms.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// ********************************************************
// Directed test programs and their expected stores
// ********************************************************
localparam int TbNumTests  = 5;
localparam int TbProgMax   = 32;	// Bytes per image
localparam int TbMaxStores = 8;

// Random ALU-immediate test
localparam int TbRandomOps = 20;
localparam logic [31:0] TbSeedInit = 32'ha693c47d;

typedef logic [0:TbProgMax-1][7:0] tbImage_t;	// Byte 0 on the left
typedef logic [cpuPkg::DefaultAddrWidth-1:0] tbAddr_t;

localparam int tbProgLen [TbNumTests] = '{9, 14, 28, 16, 17};

localparam tbImage_t tbProgImage [TbNumTests] = '{
	// LRI H, L, B then LMR B and LMI
	{8'h2E, 8'h12, 8'h36, 8'h34, 8'h0E, 8'h5A, 8'hF9, 8'h3E, 8'hC3,
	 {(TbProgMax - 9){8'h00}}},
	// JMP hides an LMI, then RLC, ACI and ADC do nothing
	{8'h2E, 8'h01, 8'h36, 8'h02, 8'h44, 8'h3E, 8'h77, 8'h02, 8'h06, 8'h99,
	 8'h0C, 8'h3E, 8'h89, 8'hF8, {(TbProgMax - 14){8'h00}}},
	// ALU chain on A with a store after each step
	{8'h2E, 8'h20, 8'h36, 8'h10, 8'h0E, 8'h0F, 8'h06, 8'h35, 8'h81, 8'hF8,
	 8'h14, 8'h05, 8'hF8, 8'hA1, 8'hF8, 8'h2C, 8'hFF, 8'hF8, 8'hB1, 8'hF8,
	 8'h91, 8'hF8, 8'h24, 8'h3C, 8'hF8, 8'h04, 8'hE0, 8'hF8,
	 {(TbProgMax - 28){8'h00}}},
	// INC and DCR wrap
	{8'h2E, 8'h00, 8'h36, 8'h40, 8'h0E, 8'hFF, 8'h08, 8'hF9, 8'h09, 8'hF9,
	 8'h16, 8'h00, 8'h11, 8'hFA, 8'h10, 8'hFA, {(TbProgMax - 16){8'h00}}},
	// LRR copies, H and L changed just before stores
	{8'h0E, 8'h6B, 8'hD1, 8'h2E, 8'h03, 8'h36, 8'h21, 8'hFA, 8'h36, 8'h22,
	 8'hFA, 8'hDA, 8'hF3, 8'h3E, 8'h55, 8'h28, 8'hFB, {(TbProgMax - 17){8'h00}}}
};

localparam int tbExpCount [TbNumTests] = '{2, 1, 8, 4, 4};

localparam tbAddr_t tbExpAddr [TbNumTests][TbMaxStores] = '{
	'{'h1234, 'h1234, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0},
	'{'h0102, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0},
	'{'h2010, 'h2010, 'h2010, 'h2010, 'h2010, 'h2010, 'h2010, 'h2010},
	'{'h0040, 'h0040, 'h0040, 'h0040, 'h0, 'h0, 'h0, 'h0},
	'{'h0321, 'h0322, 'h036B, 'h046B, 'h0, 'h0, 'h0, 'h0}
};

localparam logic [7:0] tbExpData [TbNumTests][TbMaxStores] = '{
	'{8'h5A, 8'hC3, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
	'{8'h99, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
	'{8'h44, 8'h3F, 8'h0F, 8'hF0, 8'hFF, 8'hF0, 8'h30, 8'h10},
	'{8'h00, 8'hFF, 8'hFF, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
	'{8'h6B, 8'h6B, 8'h55, 8'h6B, 8'h00, 8'h00, 8'h00, 8'h00}
};

`endif

//--- bench/tbCpu.sv
`timescale 1ns/1ps
`default_nettype none

module tbCpu;

`include "tbPrograms.svh"

	localparam int ClkPeriod   = 40;
	localparam int DriveDelay  = 2;		// After the rising edge
	localparam int ResetCycles = 3;
	localparam int DrainCycles = 16;
	localparam int RomSize     = 128;
	localparam int RandomLen   = 6 + 3 * TbRandomOps;	// Three LRI, then op + store pairs
	localparam cpuPkg::byte_t RandH = 8'h2B;
	localparam cpuPkg::byte_t RandL = 8'h7D;

	logic          CLK_I;
	logic          nRST_I;
	cpuPkg::byte_t I_DAT_I;
	tbAddr_t       I_ADDR_O;
	logic          D_WE_O;
	tbAddr_t       D_ADDR_O;
	cpuPkg::byte_t D_DAT_O;

	cpuPkg::byte_t rom [RomSize];
	tbAddr_t       expAddrQ [$];
	cpuPkg::byte_t expDataQ [$];

	integer  seed;
	int      errorCount;
	int      testErrors;
	int      testsPassed;
	int      testsFailed;
	int      cycleCount;
	int      cycleLimit;
	tbAddr_t prevAddr;
	logic    addrArmed;

	cpuTop i_dut (
		.CLK_I(CLK_I), .nRST_I(nRST_I), .I_DAT_I(I_DAT_I), .I_ADDR_O(I_ADDR_O),
		.D_WE_O(D_WE_O), .D_ADDR_O(D_ADDR_O), .D_DAT_O(D_DAT_O)
	);

	initial CLK_I = 1'b0;
	always #(ClkPeriod / 2) CLK_I = ~CLK_I;

	// ************************************************************
	// Instruction ROM, zero past the image
	// ************************************************************
	function automatic cpuPkg::byte_t romByte(tbAddr_t addr);
		if (addr < RomSize) begin
			return rom[addr];
		end else begin
			return 8'h00;
		end
	endfunction

	always @(posedge CLK_I) begin
		#DriveDelay;
		I_DAT_I = romByte(I_ADDR_O);
	end

	// Reference ALU on the OOO field, carry dropped
	function automatic cpuPkg::byte_t aluModel(logic [2:0] ooo, cpuPkg::byte_t a, cpuPkg::byte_t s);
		case (ooo)
			3'b000:  return a + s;
			3'b010:  return a - s;
			3'b100:  return a & s;
			3'b101:  return a ^ s;
			default: return a | s;
		endcase
	endfunction

	function automatic logic [2:0] opField(int sel);
		case (sel)
			0:       return 3'b000;	// ADD
			1:       return 3'b010;	// SUB
			2:       return 3'b100;	// AND
			3:       return 3'b101;	// XOR
			default: return 3'b110;	// OR
		endcase
	endfunction

	function automatic string testName(int t);
		case (t)
			0:       return "1 loads and stores";
			1:       return "2 length skipping";
			2:       return "3 ALU forwarding";
			3:       return "4 INC DCR wrap";
			4:       return "5 moves and address";
			default: return "6 random ALU immediate";
		endcase
	endfunction

	task automatic noteError();
		errorCount++;
		testErrors++;
	endtask

	task automatic waitCycle();
		@(posedge CLK_I);
		#DriveDelay;
	endtask

	// ************************************************************
	// Store and fetch address checks
	// ************************************************************
	task automatic checkStore();
		tbAddr_t       wantAddr;
		cpuPkg::byte_t wantData;
		assert (expAddrQ.size() > 0) else begin
			$display("Time %0t: store to %h with data %h when no store was expected",
			         $time, D_ADDR_O, D_DAT_O);
			noteError();
		end
		if (expAddrQ.size() > 0) begin
			wantAddr = expAddrQ.pop_front();
			wantData = expDataQ.pop_front();
			assert (D_ADDR_O === wantAddr) else begin
				$display("[FAIL] time %0t D_ADDR_O expected %h actual %h",
				         $time, wantAddr, D_ADDR_O);
				noteError();
			end
			assert (D_DAT_O === wantData) else begin
				$display("[FAIL] time %0t D_DAT_O expected %h actual %h",
				         $time, wantData, D_DAT_O);
				noteError();
			end
		end
	endtask

	always @(negedge CLK_I) begin
		if (nRST_I === 1'b1) begin
			if (D_WE_O === 1'b1) begin
				checkStore();
			end
			if (addrArmed) begin
				assert (I_ADDR_O === tbAddr_t'(prevAddr + 1'b1)) else begin
					$display("[FAIL] time %0t I_ADDR_O expected %h actual %h",
					         $time, tbAddr_t'(prevAddr + 1'b1), I_ADDR_O);
					noteError();
				end
			end
			prevAddr  = I_ADDR_O;
			addrArmed = 1'b1;
		end else begin
			addrArmed = 1'b0;	// PC restarts at zero
		end
	end

	always @(posedge CLK_I) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: the run went past %0d cycles", cycleLimit);
			$display("Done: errors found");
			$finish;
		end
	end

	// ************************************************************
	// Test setup and sequencing
	// ************************************************************
	task automatic loadDirected(int t);
		int i;
		for (i = 0; i < RomSize; i++) begin
			rom[i] = (i < TbProgMax) ? tbProgImage[t][i] : 8'h00;
		end
		for (i = 0; i < tbExpCount[t]; i++) begin
			expAddrQ.push_back(tbExpAddr[t][i]);
			expDataQ.push_back(tbExpData[t][i]);
		end
	endtask

	task automatic loadRandom();
		int            i;
		logic [31:0]   r;
		logic [2:0]    ooo;
		cpuPkg::byte_t acc;
		cpuPkg::byte_t imm;
		for (i = 0; i < RomSize; i++) begin
			rom[i] = 8'h00;
		end
		r   = $random(seed);
		acc = r[7:0];	// Random start value of A
		rom[0] = 8'h2E;	// LRI H
		rom[1] = RandH;
		rom[2] = 8'h36;	// LRI L
		rom[3] = RandL;
		rom[4] = 8'h06;	// LRI A
		rom[5] = acc;
		for (i = 0; i < TbRandomOps; i++) begin
			r   = $random(seed);
			ooo = opField(r % 5);
			r   = $random(seed);
			imm = r[7:0];
			rom[6 + 3 * i] = {2'b00, ooo, 3'b100};
			rom[7 + 3 * i] = imm;
			rom[8 + 3 * i] = 8'hF8;	// LMR A
			acc = aluModel(ooo, acc, imm);
			expAddrQ.push_back(tbAddr_t'({RandH, RandL}));
			expDataQ.push_back(acc);
		end
	endtask

	task automatic runTest(int t, int len);
		int missed;
		testErrors = 0;
		nRST_I = 1'b0;
		repeat (ResetCycles) waitCycle();
		nRST_I = 1'b1;
		repeat (len + DrainCycles) waitCycle();
		missed = expAddrQ.size();
		assert (missed == 0) else begin
			$display("Test %s ended with %0d expected stores never seen", testName(t), missed);
			noteError();
		end
		expAddrQ.delete();
		expDataQ.delete();
		if (testErrors == 0) begin
			testsPassed++;
			$display("Test %s: passed", testName(t));
		end else begin
			testsFailed++;
			$display("Test %s: failed with %0d errors", testName(t), testErrors);
		end
	endtask

	initial begin : mainSeq
		int t;
		nRST_I      = 1'b0;
		I_DAT_I     = 8'h00;
		seed        = TbSeedInit;
		errorCount  = 0;
		testErrors  = 0;
		testsPassed = 0;
		testsFailed = 0;
		cycleCount  = 0;
		addrArmed   = 1'b0;
		prevAddr    = '0;
		cycleLimit  = 64 + RandomLen + DrainCycles + ResetCycles;
		for (t = 0; t < TbNumTests; t++) begin
			cycleLimit += tbProgLen[t] + DrainCycles + ResetCycles;
		end
		waitCycle();
		for (t = 0; t < TbNumTests; t++) begin
			loadDirected(t);
			runTest(t, tbProgLen[t]);
		end
		loadRandom();
		runTest(TbNumTests, RandomLen);
		$display("Tests: %0d passed, %0d failed, %0d errors",
		         testsPassed, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
design/cpuPkg.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/cpuTop.sv
bench/tbCpu.sv
